// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing -j 0
TOP      = tb_pix_gen_game
FILELIST = project.f
OBJ_DIR  = obj_dir
LOG      = sim.log
PASS_MSG = ** PASS **

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qF "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== bench/game_model.svh ====
`ifndef game_model_svh
`define game_model_svh

// **************************************************
// reference model of the game
// **************************************************
localparam int left_x    = 40;
localparam int right_x   = 600;
localparam int top_y     = 40;
localparam int bottom_y  = 440;
localparam int bar_y0    = 10;
localparam int bar_y1    = 30;
localparam int jet_x0    = 100;
localparam int jet_x1    = 154;
localparam int jet_h     = 34;
localparam int jet_home  = 100;
localparam int rock_w    = 40;
localparam int rock_home = 550;
localparam int band_h    = 30;

localparam int band_top [8]   = '{60, 160, 360, 110, 200, 250, 290, 325};
localparam int band_speed [8] = '{3, 2, 4, 5, 3, 4, 2, 3};

int         model_speed;
int         model_y;
int         model_hits;
int         model_x [8];
bit         model_over;
bit         model_step;
logic [3:0] exp_red   = 4'h0;
logic [3:0] exp_green = 4'h0;
logic [3:0] exp_blue  = 4'h0;

function automatic bit lane_collides(input int i);
    begin
        return (model_y < band_top[i] + band_h) && (band_top[i] < model_y + jet_h)
            && (model_x[i] < jet_x1) && (jet_x0 < model_x[i] + rock_w);
    end
endfunction

// colour as {red, green, blue}
function automatic logic [11:0] predict_colour(input int x, input int y, input bit vis);
    bit border;
    bit rock;
    int bar_len;
    begin
        border = (x > right_x) || (x < left_x) || (y > bottom_y)
              || ((y > bar_y1) && (y < top_y)) || (y < bar_y0);
        bar_len = (hits_max - model_hits) * ((right_x - left_x) / hits_max);
        rock = 1'b0;
        for (int i = 0; i < n_lanes; i++)
        begin
            if ((x >= model_x[i]) && (x < model_x[i] + rock_w)
                && (y >= band_top[i]) && (y < band_top[i] + band_h))
                rock = 1'b1;
        end
        if (!vis)
            return 12'h000;
        if (model_over)
            return border ? 12'h010 : 12'hF03;
        if (border)
            return 12'h000;
        if ((y > bar_y0) && (y < bar_y1) && (x >= left_x) && (x < left_x + bar_len))
            return 12'h0F0;
        if ((x >= jet_x0) && (x < jet_x1) && (y >= model_y) && (y < model_y + jet_h))
            return 12'h00F;
        if (rock)
            return 12'hF00;
        return 12'hFFF;
    end
endfunction

// one rising edge of the game
task automatic advance_model();
    bit hit;
    bit next_step;
    int joy;
    begin
        {exp_red, exp_green, exp_blue} = predict_colour(int'(pixel_x), int'(pixel_y), video_on);
        next_step = (pixel_x == 10'd0) && (pixel_y == 10'd0) && !model_over;
        joy = int'(vry);
        if (reset)
        begin
            {exp_red, exp_green, exp_blue} = 12'h000;
            model_step  = 1'b0;
            model_over  = 1'b0;
            model_hits  = 0;
            model_y     = jet_home;
            model_speed = 1;
            for (int i = 0; i < 8; i++)
                model_x[i] = rock_home;
        end
        else
        begin
            if (model_step)
            begin
                hit = 1'b0;
                for (int i = 0; i < n_lanes; i++)
                begin
                    if (lane_collides(i))
                        hit = 1'b1;
                end
                if (hit)
                begin
                    model_hits++;
                    if (model_hits >= hits_max)
                        model_over = 1'b1;
                end
                if (joy <= 3)
                    model_y = (model_y - model_speed < top_y) ? top_y : model_y - model_speed;
                else if ((joy >= 9) && (joy <= 14))
                    model_y = (model_y + model_speed > bottom_y - jet_h)
                            ? bottom_y - jet_h : model_y + model_speed;
                for (int i = 0; i < n_lanes; i++)
                begin
                    if (model_x[i] < left_x)
                        model_x[i] = rock_home;
                    else
                        model_x[i] = model_x[i] - band_speed[i];
                end
            end
            model_step = next_step;
            if (high_s)
                model_speed = 3;
            else if (medium_s)
                model_speed = 2;
            else if (low_s)
                model_speed = 1;
        end
    end
endtask

`endif

// ==== bench/tb_pix_gen_game.sv ====
`timescale 1ns/1ps

module tb_pix_gen_game;

    localparam int clk_period   = 4;
    localparam int reset_cycles = 16;
    localparam int run_cycles   = 20000;
    localparam int total_cycles = reset_cycles + run_cycles;
    // second reset halfway, so play resumes after a game over
    localparam int rerun_cycle  = 10000;
    localparam int n_lanes      = 4;
    localparam int hits_max     = 8;

    logic       clk_d = 1'b0;
    logic       reset;
    logic [3:0] vry;
    logic [9:0] pixel_x;
    logic [9:0] pixel_y;
    logic       video_on;
    logic       high_s;
    logic       medium_s;
    logic       low_s;
    logic [3:0] red;
    logic [3:0] green;
    logic [3:0] blue;

    `include "game_model.svh"

    pix_gen_game i_pix_gen_game (
        .clk_d    (clk_d),
        .reset    (reset),
        .vry      (vry),
        .pixel_x  (pixel_x),
        .pixel_y  (pixel_y),
        .video_on (video_on),
        .high_s   (high_s),
        .medium_s (medium_s),
        .low_s    (low_s),
        .red      (red),
        .green    (green),
        .blue     (blue)
    );

    initial
    begin
        forever #(clk_period / 2) clk_d = ~clk_d;
    end

    always @(posedge clk_d)
    begin
        advance_model();
    end

    task automatic check_value(input string name, input logic [3:0] actual,
                               input logic [3:0] expected);
        begin
            if (actual !== expected)
            begin
                $display("error at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
                $display("** FAIL **");
                $fatal(1, "output mismatch");
            end
        end
    endtask

    // **************************************************
    // stimulus
    // **************************************************
    task automatic drive_inputs(input int cycle);
        int pick;
        begin
            if (cycle % 25 == 0)
            begin
                pixel_x = 10'd0;
                pixel_y = 10'd0;
            end
            else
            begin
                pixel_x = 10'($urandom % 640);
                pixel_y = 10'($urandom % 480);
            end
            video_on = (($urandom % 10) != 0);
            // up and down equally likely, so the plane wanders
            pick = int'($urandom % 8);
            if (pick < 3)
                vry = 4'($urandom % 4);
            else if (pick < 6)
                vry = 4'(9 + $urandom % 6);
            else if (pick == 6)
                vry = 4'(4 + $urandom % 5);
            else
                vry = 4'd15;
            if (($urandom % 500) == 0)
                {high_s, medium_s, low_s} = 3'($urandom % 8);
        end
    endtask

    initial
    begin
        int cycle;
        void'($urandom(96));
        reset    = 1'b1;
        vry      = 4'd7;
        pixel_x  = 10'd1;
        pixel_y  = 10'd1;
        video_on = 1'b0;
        high_s   = 1'b0;
        medium_s = 1'b0;
        low_s    = 1'b0;
        for (cycle = 1; cycle <= total_cycles; cycle++)
        begin
            @(negedge clk_d);
            check_value("red", red, exp_red);
            check_value("green", green, exp_green);
            check_value("blue", blue, exp_blue);
            reset = (cycle < reset_cycles)
                 || ((cycle >= rerun_cycle) && (cycle < rerun_cycle + reset_cycles));
            drive_inputs(cycle);
        end
        $display("** PASS **");
        $finish;
    end

    // watchdog
    initial
    begin
        #(total_cycles * clk_period * 2);
        $display("timeout: the run did not reach its end in time");
        $display("** FAIL **");
        $fatal(1, "timeout");
    end

endmodule

// ==== project.f ====
+incdir+bench
rtl/game_pkg.sv
rtl/scene_if.sv
rtl/plane_ctrl.sv
rtl/obstacle_lanes.sv
rtl/game_supervisor.sv
rtl/pixel_renderer.sv
rtl/pix_gen_game.sv
bench/tb_pix_gen_game.sv

// ==== rtl/game_pkg.sv ====
package game_pkg;

    typedef logic [9:0] coord_t;
    typedef logic [3:0] color_t;
    typedef logic [7:0] hits_t;
    typedef logic [1:0] speed_t;

    // **************************************************
    // screen geometry
    // **************************************************
    localparam coord_t play_left   = 10'd40;
    localparam coord_t play_right  = 10'd600;
    localparam coord_t play_top    = 10'd40;
    localparam coord_t play_bottom = 10'd440;

    // health bar strip above the playfield
    localparam coord_t bar_top    = 10'd10;
    localparam coord_t bar_bottom = 10'd30;

    // plane sits in a fixed column
    localparam coord_t plane_x0 = 10'd100;
    localparam coord_t plane_x1 = 10'd154;
    localparam coord_t plane_h  = 10'd34;
    localparam coord_t plane_y0 = 10'd100;

    localparam coord_t obst_w     = 10'd40;
    localparam coord_t obst_start = 10'd550;
    localparam coord_t lane_h     = 10'd30;

    // **************************************************
    // per-lane tables
    // **************************************************
    localparam int max_lanes = 8;

    // top edge of each lane band
    localparam coord_t lane_top_tbl [max_lanes] = '{
        10'd60, 10'd160, 10'd360, 10'd110,
        10'd200, 10'd250, 10'd290, 10'd325
    };

    // pixels per frame step
    localparam coord_t lane_speed_tbl [max_lanes] = '{
        10'd3, 10'd2, 10'd4, 10'd5,
        10'd3, 10'd4, 10'd2, 10'd3
    };

endpackage

// ==== rtl/game_supervisor.sv ====
`timescale 1ns/1ps

module game_supervisor #(
    parameter int n_lanes  = 4,
    parameter int hits_max = 8
) (
    input  logic             clk_d,
    input  logic             reset,
    input  game_pkg::coord_t pixel_x,
    input  game_pkg::coord_t pixel_y,
    output logic             frame_step,
    scene_if.supervisor_mp   scene
);
    import game_pkg::*;

    localparam hits_t hit_limit = hits_t'(hits_max);

    logic               at_origin;
    logic [n_lanes-1:0] lane_hit;
    logic               any_hit;
    hits_t              hit_next;

    // one step per frame, at the top-left pixel
    assign at_origin = (pixel_x == '0) && (pixel_y == '0);

    // **************************************************
    // collision check, half-open bands
    // **************************************************
    always_comb
    begin
        for (int i = 0; i < n_lanes; i++)
        begin
            lane_hit[i] = (scene.plane_y < lane_top_tbl[i] + lane_h)
                       && (lane_top_tbl[i] < scene.plane_y + plane_h)
                       && (scene.obstacle_x[i] < plane_x1)
                       && (plane_x0 < scene.obstacle_x[i] + obst_w);
        end
    end

    assign any_hit  = |lane_hit;
    assign hit_next = scene.hit_count + 8'd1;

    always_ff @(posedge clk_d)
    begin
        if (reset)
        begin
            frame_step      <= 1'b0;
            scene.hit_count <= '0;
            scene.game_over <= 1'b0;
        end
        else
        begin
            frame_step <= at_origin && !scene.game_over;
            // several lanes at once still count as one hit
            if (frame_step && any_hit)
            begin
                scene.hit_count <= hit_next;
                if (hit_next == hit_limit)
                    scene.game_over <= 1'b1;
            end
        end
    end

endmodule

// ==== rtl/obstacle_lanes.sv ====
`timescale 1ns/1ps

module obstacle_lanes #(
    parameter int n_lanes = 4
) (
    input  logic      clk_d,
    input  logic      reset,
    input  logic      frame_step,
    scene_if.lanes_mp scene
);
    import game_pkg::*;

    coord_t [n_lanes-1:0] x_next;

    // **************************************************
    // scroll left, wrap to the right edge
    // **************************************************
    always_comb
    begin
        for (int i = 0; i < n_lanes; i++)
        begin
            // past the left wall, reload instead of moving
            if (scene.obstacle_x[i] < play_left)
                x_next[i] = obst_start;
            else
                x_next[i] = scene.obstacle_x[i] - lane_speed_tbl[i];
        end
    end

    always_ff @(posedge clk_d)
    begin
        if (reset)
        begin
            for (int i = 0; i < n_lanes; i++)
            begin
                scene.obstacle_x[i] <= obst_start;
            end
        end
        else if (frame_step)
        begin
            scene.obstacle_x <= x_next;
        end
    end

endmodule

// ==== rtl/pix_gen_game.sv ====
`timescale 1ns/1ps

module pix_gen_game #(
    parameter int n_lanes  = 4,
    parameter int hits_max = 8
) (
    input  logic             clk_d,
    input  logic             reset,
    input  logic [3:0]       vry,
    input  game_pkg::coord_t pixel_x,
    input  game_pkg::coord_t pixel_y,
    input  logic             video_on,
    input  logic             high_s,
    input  logic             medium_s,
    input  logic             low_s,
    output game_pkg::color_t red,
    output game_pkg::color_t green,
    output game_pkg::color_t blue
);

    logic frame_step;

    // game state shared by all blocks
    scene_if #(.n_lanes(n_lanes)) scene ();

    plane_ctrl i_plane_ctrl (
        .clk_d      (clk_d),
        .reset      (reset),
        .frame_step (frame_step),
        .high_s     (high_s),
        .medium_s   (medium_s),
        .low_s      (low_s),
        .vry        (vry),
        .scene      (scene.plane_mp)
    );

    obstacle_lanes #(.n_lanes(n_lanes)) i_obstacle_lanes (
        .clk_d      (clk_d),
        .reset      (reset),
        .frame_step (frame_step),
        .scene      (scene.lanes_mp)
    );

    game_supervisor #(.n_lanes(n_lanes), .hits_max(hits_max)) i_game_supervisor (
        .clk_d      (clk_d),
        .reset      (reset),
        .pixel_x    (pixel_x),
        .pixel_y    (pixel_y),
        .frame_step (frame_step),
        .scene      (scene.supervisor_mp)
    );

    pixel_renderer #(.n_lanes(n_lanes), .hits_max(hits_max)) i_pixel_renderer (
        .clk_d      (clk_d),
        .reset      (reset),
        .video_on   (video_on),
        .pixel_x    (pixel_x),
        .pixel_y    (pixel_y),
        .scene      (scene.render_mp),
        .red        (red),
        .green      (green),
        .blue       (blue)
    );

endmodule

// ==== rtl/pixel_renderer.sv ====
`timescale 1ns/1ps

module pixel_renderer #(
    parameter int n_lanes  = 4,
    parameter int hits_max = 8
) (
    input  logic             clk_d,
    input  logic             reset,
    input  logic             video_on,
    input  game_pkg::coord_t pixel_x,
    input  game_pkg::coord_t pixel_y,
    scene_if.render_mp       scene,
    output game_pkg::color_t red,
    output game_pkg::color_t green,
    output game_pkg::color_t blue
);
    import game_pkg::*;

    localparam hits_t hit_limit = hits_t'(hits_max);
    // bar shrinks by one step per hit
    localparam int bar_step = (play_right - play_left) / hits_max;

    coord_t bar_end;
    logic   in_border;
    logic   in_bar;
    logic   in_plane;
    logic   in_obstacle;
    color_t red_next;
    color_t green_next;
    color_t blue_next;

    assign bar_end = play_left
                   + coord_t'(hit_limit - scene.hit_count) * coord_t'(bar_step);

    // **************************************************
    // region decode
    // **************************************************
    // includes the gap between bar and playfield
    assign in_border = (pixel_x > play_right) || (pixel_x < play_left)
                    || (pixel_y > play_bottom)
                    || ((pixel_y > bar_bottom) && (pixel_y < play_top))
                    || (pixel_y < bar_top);

    assign in_bar = (pixel_y > bar_top) && (pixel_y < bar_bottom)
                 && (pixel_x >= play_left) && (pixel_x < bar_end);

    assign in_plane = (pixel_x >= plane_x0) && (pixel_x < plane_x1)
                   && (pixel_y >= scene.plane_y)
                   && (pixel_y < scene.plane_y + plane_h);

    always_comb
    begin
        in_obstacle = 1'b0;
        for (int i = 0; i < n_lanes; i++)
        begin
            if ((pixel_x >= scene.obstacle_x[i])
                && (pixel_x < scene.obstacle_x[i] + obst_w)
                && (pixel_y >= lane_top_tbl[i])
                && (pixel_y < lane_top_tbl[i] + lane_h))
                in_obstacle = 1'b1;
        end
    end

    // **************************************************
    // colour priority
    // **************************************************
    always_comb
    begin
        if (!video_on)
            {red_next, green_next, blue_next} = {4'h0, 4'h0, 4'h0};
        else if (scene.game_over)
        begin
            // flat end screen
            if (in_border)
                {red_next, green_next, blue_next} = {4'h0, 4'h1, 4'h0};
            else
                {red_next, green_next, blue_next} = {4'hF, 4'h0, 4'h3};
        end
        else if (in_border)
            {red_next, green_next, blue_next} = {4'h0, 4'h0, 4'h0};
        else if (in_bar)
            {red_next, green_next, blue_next} = {4'h0, 4'hF, 4'h0};
        else if (in_plane)
            {red_next, green_next, blue_next} = {4'h0, 4'h0, 4'hF};
        else if (in_obstacle)
            {red_next, green_next, blue_next} = {4'hF, 4'h0, 4'h0};
        else
            {red_next, green_next, blue_next} = {4'hF, 4'hF, 4'hF};
    end

    always_ff @(posedge clk_d)
    begin
        if (reset)
        begin
            red   <= '0;
            green <= '0;
            blue  <= '0;
        end
        else
        begin
            red   <= red_next;
            green <= green_next;
            blue  <= blue_next;
        end
    end

endmodule

// ==== rtl/plane_ctrl.sv ====
`timescale 1ns/1ps

module plane_ctrl (
    input  logic       clk_d,
    input  logic       reset,
    input  logic       frame_step,
    input  logic       high_s,
    input  logic       medium_s,
    input  logic       low_s,
    input  logic [3:0] vry,
    scene_if.plane_mp  scene
);
    import game_pkg::*;

    // travel limits for the plane's top edge
    localparam coord_t y_min = play_top;
    localparam coord_t y_max = play_bottom - plane_h;

    speed_t speed;
    coord_t step;
    coord_t y_down;
    coord_t y_up;
    coord_t y_next;

    // speed select, high switch wins
    always_ff @(posedge clk_d)
    begin
        if (reset)
            speed <= 2'd1;
        else if (high_s)
            speed <= 2'd3;
        else if (medium_s)
            speed <= 2'd2;
        else if (low_s)
            speed <= 2'd1;
    end

    assign step   = {8'd0, speed};
    assign y_down = scene.plane_y + step;
    assign y_up   = scene.plane_y - step;

    // joystick low end pushes up, high end pushes down
    always_comb
    begin
        if ((vry >= 4'd9) && (vry <= 4'd14))
            y_next = (y_down > y_max) ? y_max : y_down;
        else if (vry <= 4'd3)
            y_next = (y_up < y_min) ? y_min : y_up;
        else
            y_next = scene.plane_y;
    end

    always_ff @(posedge clk_d)
    begin
        if (reset)
            scene.plane_y <= plane_y0;
        else if (frame_step)
            scene.plane_y <= y_next;
    end

endmodule

// ==== rtl/scene_if.sv ====
`timescale 1ns/1ps

interface scene_if #(
    parameter int n_lanes = 4
) ();
    import game_pkg::*;

    coord_t                plane_y;
    // left edge of each lane's obstacle
    coord_t [n_lanes-1:0]  obstacle_x;
    hits_t                 hit_count;
    logic                  game_over;

    modport plane_mp (output plane_y);

    modport lanes_mp (output obstacle_x);

    modport supervisor_mp (
        input  plane_y,
        input  obstacle_x,
        output hit_count,
        output game_over
    );

    modport render_mp (input plane_y, obstacle_x, hit_count, game_over);

endinterface
